// ==== rtl/hazard_consts.svh ====
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// register file index width, x0..x31
`define HZ_REG_AW 5

`define HZ_INST_W 32

// RV base opcodes, inst[6:0]
`define HZ_OP_LOAD   7'b0000011
`define HZ_OP_STORE  7'b0100011
`define HZ_OP_BRANCH 7'b1100011
`define HZ_OP_ALU    7'b0110011
`define HZ_OP_ALUI   7'b0010011
`define HZ_OP_LUI    7'b0110111
`define HZ_OP_JAL    7'b1101111

`endif

// ==== rtl/hazard_pkg.sv ====
`include "hazard_consts.svh"

package hazard_pkg;

    typedef enum logic [2:0] {
        CLS_ALU,    // reg-reg
        CLS_ALUI,   // reg-imm
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_NOSRC   // lui, jal, unknown
    } inst_class_e;

    // where an operand value comes from
    typedef enum logic [1:0] {
        FWD_NONE,   // register file
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_src_e;

    typedef struct packed {
        logic [`HZ_REG_AW-1:0] rs1;
        logic [`HZ_REG_AW-1:0] rs2;
        logic [`HZ_REG_AW-1:0] rd;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  rd_write;
        inst_class_e           cls;
    } dec_inst_t;

    typedef struct packed {
        logic                  valid;
        logic [`HZ_REG_AW-1:0] rd;
        logic                  is_load;
    } stage_slot_t;

    typedef struct packed {
        fwd_src_e              fwd1;
        fwd_src_e              fwd2;
        logic [`HZ_REG_AW-1:0] rd;
        logic                  rd_write;
        logic                  stalled;
    } hazard_res_t;

endpackage

// ==== rtl/inst_decode.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module inst_decode (
    input  logic [`HZ_INST_W-1:0] inst,
    output hazard_pkg::dec_inst_t dec
);

    logic [6:0] opcode;
    logic       has_rd;

    assign opcode = inst[6:0];

    always_comb begin
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];
        dec.use_rs1 = 1'b0;
        dec.use_rs2 = 1'b0;
        has_rd = 1'b0;
        dec.cls = hazard_pkg::CLS_NOSRC;
        case (opcode)
            `HZ_OP_ALU: begin
                dec.cls = hazard_pkg::CLS_ALU;
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
                has_rd = 1'b1;
            end
            `HZ_OP_ALUI: begin
                dec.cls = hazard_pkg::CLS_ALUI;
                dec.use_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            `HZ_OP_LOAD: begin
                dec.cls = hazard_pkg::CLS_LOAD;
                dec.use_rs1 = 1'b1; // base address
                has_rd = 1'b1;
            end
            `HZ_OP_STORE: begin
                dec.cls = hazard_pkg::CLS_STORE;
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1; // store data
            end
            `HZ_OP_BRANCH: begin
                dec.cls = hazard_pkg::CLS_BRANCH;
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
            end
            `HZ_OP_LUI, `HZ_OP_JAL: begin
                has_rd = 1'b1; // no sources, still writes rd
            end
            default: begin
                has_rd = 1'b0; // unknown opcode acts as a nop
            end
        endcase
        dec.rd_write = has_rd && (inst[11:7] != '0); // x0 writes are dropped
    end

endmodule

// ==== rtl/operand_hazard.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module operand_hazard (
    input  logic [`HZ_REG_AW-1:0]   src,
    input  logic                    src_used,
    input  hazard_pkg::stage_slot_t ex_slot,
    input  hazard_pkg::stage_slot_t mem_slot,
    input  hazard_pkg::stage_slot_t wb_slot,
    output hazard_pkg::fwd_src_e    fwd,
    output logic                    load_use
);

    logic live;
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // x0 is hardwired, never forwarded
    assign live = src_used && (src != '0);

    assign ex_hit  = live && ex_slot.valid  && (ex_slot.rd  == src);
    assign mem_hit = live && mem_slot.valid && (mem_slot.rd == src);
    assign wb_hit  = live && wb_slot.valid  && (wb_slot.rd  == src);

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            fwd = hazard_pkg::FWD_EX;
        end else if (mem_hit) begin
            fwd = hazard_pkg::FWD_MEM;
        end else if (wb_hit) begin
            fwd = hazard_pkg::FWD_WB;
        end else begin
            fwd = hazard_pkg::FWD_NONE;
        end
    end

    // load data is not ready until MEM
    assign load_use = ex_hit && ex_slot.is_load;

endmodule

// ==== rtl/inflight_track.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module inflight_track (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_valid,
    input  logic [`HZ_REG_AW-1:0]   push_rd,
    input  logic                    push_load,
    output hazard_pkg::stage_slot_t ex_slot,
    output hazard_pkg::stage_slot_t mem_slot,
    output hazard_pkg::stage_slot_t wb_slot
);

    hazard_pkg::stage_slot_t ex_q;
    hazard_pkg::stage_slot_t mem_q;
    hazard_pkg::stage_slot_t wb_q;

    // valid bits, bubble when nothing pushed
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q.valid  <= 1'b0;
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            ex_q.valid  <= push_valid;
            mem_q.valid <= ex_q.valid;
            wb_q.valid  <= mem_q.valid;
        end
    end

    // payload follows the valid bits down the pipe
    always_ff @(posedge clk) begin
        ex_q.rd      <= push_rd;
        ex_q.is_load <= push_load;
        mem_q.rd      <= ex_q.rd;
        mem_q.is_load <= ex_q.is_load;
        wb_q.rd      <= mem_q.rd;
        wb_q.is_load <= mem_q.is_load;
    end

    assign ex_slot  = ex_q;
    assign mem_slot = mem_q;
    assign wb_slot  = wb_q;

endmodule

// ==== rtl/issue_control.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module issue_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      iss_valid,
    input  logic [`HZ_INST_W-1:0]     iss_inst,
    input  hazard_pkg::fwd_src_e      fwd [2],
    input  logic [1:0]                load_use,
    input  hazard_pkg::dec_inst_t     dec,
    output logic [`HZ_INST_W-1:0]     cur_inst,
    output logic                      busy,
    output logic                      push_valid,
    output logic                      res_valid,
    output hazard_pkg::hazard_res_t   res
);

    logic [`HZ_INST_W-1:0] held_inst;
    logic                  cur_valid;
    logic                  stall;
    logic                  accept;

    // held instruction has priority, source is quiet while busy
    assign cur_inst  = busy ? held_inst : iss_inst;
    assign cur_valid = busy | iss_valid;

    assign stall  = cur_valid & (|load_use);
    assign accept = cur_valid & ~stall;

    // only writers become producers
    assign push_valid = accept & dec.rd_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            busy      <= stall;
            res_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            held_inst <= cur_inst;
        end
    end

    // result payload, qualified by res_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            res.fwd1     <= fwd[0];
            res.fwd2     <= fwd[1];
            res.rd       <= dec.rd;
            res.rd_write <= dec.rd_write;
            res.stalled  <= busy; // second pass of a held inst
        end
    end

endmodule

// ==== rtl/hazard_unit_top.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module hazard_unit_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    iss_valid,
    input  logic [`HZ_INST_W-1:0]   iss_inst,
    output logic                    busy,
    output logic                    res_valid,
    output hazard_pkg::hazard_res_t res
);

    logic [`HZ_INST_W-1:0]   cur_inst;
    hazard_pkg::dec_inst_t   dec;
    hazard_pkg::stage_slot_t ex_slot;
    hazard_pkg::stage_slot_t mem_slot;
    hazard_pkg::stage_slot_t wb_slot;
    hazard_pkg::fwd_src_e    fwd [2];
    logic [1:0]              load_use;
    logic                    push_valid;
    logic [`HZ_REG_AW-1:0]   src [2];
    logic [1:0]              src_used;

    inst_decode inst_decode_inst (
        .inst (cur_inst),
        .dec  (dec)
    );

    assign src[0]      = dec.rs1;
    assign src[1]      = dec.rs2;
    assign src_used[0] = dec.use_rs1;
    assign src_used[1] = dec.use_rs2;

    // one checker per source operand
    for (genvar i = 0; i < 2; i++) begin : operand_chk
        operand_hazard operand_hazard_inst (
            .src      (src[i]),
            .src_used (src_used[i]),
            .ex_slot  (ex_slot),
            .mem_slot (mem_slot),
            .wb_slot  (wb_slot),
            .fwd      (fwd[i]),
            .load_use (load_use[i])
        );
    end

    inflight_track inflight_track_inst (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_rd    (dec.rd),
        .push_load  (dec.cls == hazard_pkg::CLS_LOAD),
        .ex_slot    (ex_slot),
        .mem_slot   (mem_slot),
        .wb_slot    (wb_slot)
    );

    issue_control issue_control_inst (
        .clk        (clk),
        .rst        (rst),
        .iss_valid  (iss_valid),
        .iss_inst   (iss_inst),
        .fwd        (fwd),
        .load_use   (load_use),
        .dec        (dec),
        .cur_inst   (cur_inst),
        .busy       (busy),
        .push_valid (push_valid),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

// ==== bench/hazard_checker.sv ====
`timescale 1ns/10ps

module hazard_checker (
    input logic clk,
    input logic rst,
    input logic iss_valid,
    input logic busy,
    input logic res_valid
);

    int fail_cnt = 0; // assertion failures so far

    reset_quiet: assert property (@(posedge clk) rst |=> (!busy && !res_valid))
        else begin
            fail_cnt++;
            $error("busy or res_valid high right after reset");
        end

    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !iss_valid)
        else begin
            fail_cnt++;
            $error("issue strobe while busy");
        end

    // a load-use stall lasts exactly one cycle
    single_stall: assert property (@(posedge clk) disable iff (rst) busy |=> !busy)
        else begin
            fail_cnt++;
            $error("busy high for two consecutive cycles");
        end

    stall_resolves: assert property (@(posedge clk) disable iff (rst) busy |=> res_valid)
        else begin
            fail_cnt++;
            $error("held instruction produced no result after the stall");
        end

endmodule

// ==== bench/hazard_unit_tb.sv ====
`include "hazard_consts.svh"
`timescale 1ns/10ps

module hazard_unit_tb;

    localparam int NUM_ISSUE      = 400;
    localparam int TIMEOUT_CYCLES = NUM_ISSUE * 3 + 50;

    logic                    clk;
    logic                    rst;
    logic                    iss_valid;
    logic [`HZ_INST_W-1:0]   iss_inst;
    logic                    busy;
    logic                    res_valid;
    hazard_pkg::hazard_res_t res;

    integer seed;
    int     err_cnt;
    int     check_cnt;
    int     stall_cnt;
    int     assert_cnt;
    int     cycle_cnt;

    // reference shadow of the pipe, index 0 is EX
    logic                    m_valid [3];
    logic [`HZ_REG_AW-1:0]   m_rd [3];
    logic                    m_load [3];
    logic                    m_busy;
    hazard_pkg::dec_inst_t   m_held;
    logic                    exp_valid;
    hazard_pkg::hazard_res_t exp_res;

    hazard_unit_top hazard_unit_top_inst (
        .clk       (clk),
        .rst       (rst),
        .iss_valid (iss_valid),
        .iss_inst  (iss_inst),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res)
    );

    bind hazard_unit_top hazard_checker hazard_checker_inst (
        .clk       (clk),
        .rst       (rst),
        .iss_valid (iss_valid),
        .busy      (busy),
        .res_valid (res_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [`HZ_REG_AW-1:0] pick_reg();
        logic [31:0] r;
        r = $unsigned($random(seed)) % 32'd6; // x0..x5 only
        return r[`HZ_REG_AW-1:0];
    endfunction

    task automatic make_inst(output logic [31:0] word, output hazard_pkg::dec_inst_t d);
        logic [31:0] pick;
        logic [6:0]  opc;
        word = $random(seed); // immediates and funct bits stay random
        pick = $unsigned($random(seed)) % 32'd8;
        d.rs1 = pick_reg();
        d.rs2 = pick_reg();
        d.rd = pick_reg();
        d.use_rs1 = 1'b1;
        d.use_rs2 = 1'b0;
        case (pick)
            0, 1: begin
                d.cls = hazard_pkg::CLS_ALU;
                d.use_rs2 = 1'b1;
                opc = `HZ_OP_ALU;
            end
            2: begin
                d.cls = hazard_pkg::CLS_ALUI;
                opc = `HZ_OP_ALUI;
            end
            3, 4: begin
                d.cls = hazard_pkg::CLS_LOAD; // weighted up for stalls
                opc = `HZ_OP_LOAD;
            end
            5: begin
                d.cls = hazard_pkg::CLS_STORE;
                d.use_rs2 = 1'b1;
                opc = `HZ_OP_STORE;
            end
            6: begin
                d.cls = hazard_pkg::CLS_BRANCH;
                d.use_rs2 = 1'b1;
                opc = `HZ_OP_BRANCH;
            end
            default: begin
                d.cls = hazard_pkg::CLS_NOSRC;
                d.use_rs1 = 1'b0;
                opc = word[31] ? `HZ_OP_LUI : `HZ_OP_JAL;
            end
        endcase
        d.rd_write = (d.cls != hazard_pkg::CLS_STORE) && (d.cls != hazard_pkg::CLS_BRANCH)
                     && (d.rd != '0);
        word[6:0] = opc;
        word[11:7] = d.rd;
        word[19:15] = d.rs1;
        word[24:20] = d.rs2;
    endtask

    function automatic hazard_pkg::fwd_src_e model_fwd(input logic [`HZ_REG_AW-1:0] src,
                                                       input logic used, output logic lu);
        lu = 1'b0;
        model_fwd = hazard_pkg::FWD_NONE;
        if (used && (src != '0)) begin
            if (m_valid[0] && (m_rd[0] == src)) begin
                model_fwd = hazard_pkg::FWD_EX;
                lu = m_load[0];
            end else if (m_valid[1] && (m_rd[1] == src)) begin
                model_fwd = hazard_pkg::FWD_MEM;
            end else if (m_valid[2] && (m_rd[2] == src)) begin
                model_fwd = hazard_pkg::FWD_WB;
            end
        end
    endfunction

    // predicts the outputs after the next edge and advances the shadow
    task automatic evaluate(input logic take, input hazard_pkg::dec_inst_t nd);
        hazard_pkg::dec_inst_t cur;
        hazard_pkg::fwd_src_e  f1;
        hazard_pkg::fwd_src_e  f2;
        logic                  lu1;
        logic                  lu2;
        logic                  cur_valid;
        logic                  push;
        logic                  next_busy;
        cur = m_busy ? m_held : nd;
        cur_valid = m_busy || take;
        f1 = model_fwd(cur.rs1, cur.use_rs1, lu1);
        f2 = model_fwd(cur.rs2, cur.use_rs2, lu2);
        push = 1'b0;
        next_busy = 1'b0;
        exp_valid = 1'b0;
        if (cur_valid && (lu1 || lu2)) begin
            next_busy = 1'b1;
            m_held = cur;
            stall_cnt++;
        end else if (cur_valid) begin
            exp_valid = 1'b1;
            exp_res.fwd1 = f1;
            exp_res.fwd2 = f2;
            exp_res.rd = cur.rd;
            exp_res.rd_write = cur.rd_write;
            exp_res.stalled = m_busy;
            push = cur.rd_write;
        end
        m_valid[2] = m_valid[1];
        m_rd[2] = m_rd[1];
        m_load[2] = m_load[1];
        m_valid[1] = m_valid[0];
        m_rd[1] = m_rd[0];
        m_load[1] = m_load[0];
        m_valid[0] = push; // bubble unless a writer was accepted
        m_rd[0] = cur.rd;
        m_load[0] = (cur.cls == hazard_pkg::CLS_LOAD);
        m_busy = next_busy;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: time %0t, %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_value("busy", 32'(busy), 32'(m_busy));
        check_value("res_valid", 32'(res_valid), 32'(exp_valid));
        if (exp_valid && res_valid) begin
            check_value("res.fwd1", 32'(res.fwd1), 32'(exp_res.fwd1));
            check_value("res.fwd2", 32'(res.fwd2), 32'(exp_res.fwd2));
            check_value("res.rd", 32'(res.rd), 32'(exp_res.rd));
            check_value("res.rd_write", 32'(res.rd_write), 32'(exp_res.rd_write));
            check_value("res.stalled", 32'(res.stalled), 32'(exp_res.stalled));
        end
    endtask

    initial begin
        int                    issued;
        hazard_pkg::dec_inst_t nd;
        logic [31:0]           word;
        logic [31:0]           coin;
        logic                  take;
        seed = 32'h88d3_0650;
        err_cnt = 0;
        check_cnt = 0;
        stall_cnt = 0;
        issued = 0;
        rst = 1'b1;
        iss_valid = 1'b0;
        iss_inst = '0;
        for (int i = 0; i < 3; i++) begin
            m_valid[i] = 1'b0;
            m_rd[i] = '0;
            m_load[i] = 1'b0;
        end
        m_busy = 1'b0;
        m_held = '0;
        exp_valid = 1'b0;
        exp_res = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_outputs(); // quiet right after reset
        while (issued < NUM_ISSUE) begin
            take = 1'b0;
            nd = '0;
            word = $random(seed);
            if (!m_busy) begin
                coin = $random(seed);
                if (coin[1:0] != 2'b00) begin // about one idle cycle in four
                    make_inst(word, nd);
                    take = 1'b1;
                    issued++;
                end
            end
            iss_valid = take;
            iss_inst = word;
            evaluate(take, nd);
            @(posedge clk);
            #1;
            compare_outputs();
        end
        iss_valid = 1'b0;
        nd = '0;
        repeat (4) begin
            evaluate(1'b0, nd);
            @(posedge clk);
            #1;
            compare_outputs();
        end
        assert_cnt = hazard_unit_top_inst.hazard_checker_inst.fail_cnt;
        $display("checks %0d, stalls %0d, errors %0d, assertion failures %0d",
                 check_cnt, stall_cnt, err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/hazard_pkg.sv
rtl/inst_decode.sv
rtl/operand_hazard.sv
rtl/inflight_track.sv
rtl/issue_control.sv
rtl/hazard_unit_top.sv
bench/hazard_checker.sv
bench/hazard_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hazard unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hazard_unit_tb \
    -f verilog.f -o hazard_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/hazard_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
